/* verilog/spram_pkg.sv */
`default_nettype none

package spram_pkg;

    // geometry of the one hardened macro we tile with
    parameter int macro_aw = 6;     // 64 words deep
    parameter int macro_dw = 32;    // 32 bits wide

    // AXI4-Lite side
    parameter int axil_aw = 16;     // byte address width

    parameter logic [1:0] resp_okay   = 2'b00;
    parameter logic [1:0] resp_slverr = 2'b10;

endpackage

`default_nettype wire

/* verilog/sram_macro.sv */
`default_nettype none

module sram_macro
    import spram_pkg::*;
(
    input  logic                clk,
    input  logic                ce,       // chip enable
    input  logic                we,       // write enable
    input  logic [macro_dw-1:0] w_mask,   // per bit write mask
    input  logic [macro_aw-1:0] addr,
    input  logic [macro_dw-1:0] din,
    output logic [macro_dw-1:0] dout      // registered read data
);

    logic [macro_dw-1:0] mem [2**macro_aw];

    always_ff @(posedge clk) begin
        if (ce && we) begin
            mem[addr] <= (mem[addr] & ~w_mask) | (din & w_mask);  // masked bits only
        end else if (ce) begin
            dout <= mem[addr];   // holds while ce low
        end
    end

endmodule

`default_nettype wire

/* verilog/spram_tiled.sv */
`default_nettype none

module spram_tiled
    import spram_pkg::*;
#(
    parameter int DW = 32,
    parameter int AW = 8
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          ce,
    input  logic          we,
    input  logic [DW-1:0] wmask,
    input  logic [AW-1:0] addr,
    input  logic [DW-1:0] din,
    output logic [DW-1:0] dout
);

    localparam int n_banks = 2 ** (AW - macro_aw);        // depth tiling
    localparam int n_cols  = DW / macro_dw;               // width tiling
    localparam int bank_w  = (AW > macro_aw) ? AW - macro_aw : 1;

    logic [bank_w-1:0]   bank_sel;    // bank decoded from addr
    logic [bank_w-1:0]   bank_q;      // bank of the last read
    logic [macro_aw-1:0] macro_addr;
    logic [n_banks-1:0]  bank_ce;
    logic [n_banks-1:0]  bank_we;
    wire  [DW-1:0]       bank_word [n_banks];   // full-width output per bank

    assign macro_addr = addr[macro_aw-1:0];

    // one bank needs no select bits at all
    if (n_banks == 1) begin : g_one_bank
        assign bank_sel = '0;
    end else begin : g_many_banks
        assign bank_sel = addr[AW-1:macro_aw];
    end

    for (genvar b = 0; b < n_banks; b++) begin : g_bank
        assign bank_ce[b] = ce && (bank_sel == bank_w'(b));
        assign bank_we[b] = we && (bank_sel == bank_w'(b));

        for (genvar c = 0; c < n_cols; c++) begin : g_col
            sram_macro u_macro (
                .clk    (clk),
                .ce     (bank_ce[b]),
                .we     (bank_we[b]),
                .w_mask (wmask[c*macro_dw +: macro_dw]),
                .addr   (macro_addr),
                .din    (din[c*macro_dw +: macro_dw]),
                .dout   (bank_word[b][c*macro_dw +: macro_dw])
            );
        end
    end

    // macro outputs are registered, so remember which bank was read
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bank_q <= '0;
        end else if (ce && !we) begin
            bank_q <= bank_sel;
        end
    end

    // and-or output mux over the banks
    always_comb begin
        dout = '0;
        for (int b = 0; b < n_banks; b++) begin
            dout = dout | ({DW{bank_q == bank_w'(b)}} & bank_word[b]);
        end
    end

endmodule

`default_nettype wire

/* verilog/axil_spram_ctrl.sv */
`default_nettype none

module axil_spram_ctrl
    import spram_pkg::*;
#(
    parameter int DW = 32,
    parameter int AW = 8
) (
    input  logic               clk,
    input  logic               rst_n,
    // write address
    input  logic               awvalid,
    output logic               awready,
    input  logic [axil_aw-1:0] awaddr,
    // write data
    input  logic               wvalid,
    output logic               wready,
    input  logic [DW-1:0]      wdata,
    input  logic [DW/8-1:0]    wstrb,
    // write response
    output logic               bvalid,
    input  logic               bready,
    output logic [1:0]         bresp,
    // read address
    input  logic               arvalid,
    output logic               arready,
    input  logic [axil_aw-1:0] araddr,
    // read data
    output logic               rvalid,
    input  logic               rready,
    output logic [DW-1:0]      rdata,
    output logic [1:0]         rresp,
    // memory side
    output logic               mem_ce,
    output logic               mem_we,
    output logic [DW-1:0]      mem_wmask,
    output logic [AW-1:0]      mem_addr,
    output logic [DW-1:0]      mem_din,
    input  logic [DW-1:0]      mem_dout
);

    localparam int off_w = $clog2(DW / 8);   // byte offset bits within a word

    typedef enum logic [1:0] {
        st_idle,
        st_rd_wait,
        st_b_pend,
        st_r_pend
    } state_t;

    state_t        state;
    logic          wr_go;      // aw and w handshake this cycle
    logic          rd_go;      // ar handshake this cycle
    logic          aw_ok;      // write address in range
    logic          ar_ok;      // read address in range
    logic [1:0]    resp_q;     // shared by b and r, only one is ever pending
    logic [DW-1:0] rdata_q;

    assign aw_ok = (awaddr[axil_aw-1:off_w+AW] == '0);
    assign ar_ok = (araddr[axil_aw-1:off_w+AW] == '0);

    // writes win when both are offered
    assign wr_go = (state == st_idle) && awvalid && wvalid;
    assign rd_go = (state == st_idle) && arvalid && !(awvalid && wvalid);

    assign awready = wr_go;
    assign wready  = wr_go;
    assign arready = rd_go;

    assign bvalid = (state == st_b_pend);
    assign bresp  = resp_q;
    assign rvalid = (state == st_r_pend);
    assign rresp  = resp_q;
    assign rdata  = rdata_q;

    // memory strobes go out in the handshake cycle
    assign mem_ce   = (wr_go && aw_ok) || (rd_go && ar_ok);
    assign mem_we   = wr_go && aw_ok;
    assign mem_addr = wr_go ? awaddr[off_w +: AW] : araddr[off_w +: AW];
    assign mem_din  = wdata;

    always_comb begin
        for (int i = 0; i < DW / 8; i++) begin
            mem_wmask[8*i +: 8] = {8{wstrb[i]}};   // byte strobe to bit mask
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (wr_go) begin
                        state <= st_b_pend;
                    end else if (rd_go) begin
                        state <= st_rd_wait;
                    end
                end
                st_rd_wait: state <= st_r_pend;   // macro output lands here
                st_b_pend: begin
                    if (bready) begin
                        state <= st_idle;
                    end
                end
                st_r_pend: begin
                    if (rready) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_go) begin
            resp_q <= aw_ok ? resp_okay : resp_slverr;
        end else if (rd_go) begin
            resp_q <= ar_ok ? resp_okay : resp_slverr;
        end
        if (state == st_rd_wait) begin
            rdata_q <= (resp_q == resp_okay) ? mem_dout : '0;   // zero on slverr
        end
    end

endmodule

`default_nettype wire

/* verilog/axil_spram_top.sv */
`default_nettype none

module axil_spram_top
    import spram_pkg::*;
#(
    parameter int DW = 32,
    parameter int AW = 8
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               awvalid,
    output logic               awready,
    input  logic [axil_aw-1:0] awaddr,
    input  logic               wvalid,
    output logic               wready,
    input  logic [DW-1:0]      wdata,
    input  logic [DW/8-1:0]    wstrb,
    output logic               bvalid,
    input  logic               bready,
    output logic [1:0]         bresp,
    input  logic               arvalid,
    output logic               arready,
    input  logic [axil_aw-1:0] araddr,
    output logic               rvalid,
    input  logic               rready,
    output logic [DW-1:0]      rdata,
    output logic [1:0]         rresp
);

    logic          mem_ce;
    logic          mem_we;
    logic [DW-1:0] mem_wmask;
    logic [AW-1:0] mem_addr;    // word address
    logic [DW-1:0] mem_din;
    logic [DW-1:0] mem_dout;

    axil_spram_ctrl #(
        .DW (DW),
        .AW (AW)
    ) u_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .awvalid   (awvalid),
        .awready   (awready),
        .awaddr    (awaddr),
        .wvalid    (wvalid),
        .wready    (wready),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .bvalid    (bvalid),
        .bready    (bready),
        .bresp     (bresp),
        .arvalid   (arvalid),
        .arready   (arready),
        .araddr    (araddr),
        .rvalid    (rvalid),
        .rready    (rready),
        .rdata     (rdata),
        .rresp     (rresp),
        .mem_ce    (mem_ce),
        .mem_we    (mem_we),
        .mem_wmask (mem_wmask),
        .mem_addr  (mem_addr),
        .mem_din   (mem_din),
        .mem_dout  (mem_dout)
    );

    spram_tiled #(
        .DW (DW),
        .AW (AW)
    ) u_mem (
        .clk   (clk),
        .rst_n (rst_n),
        .ce    (mem_ce),
        .we    (mem_we),
        .wmask (mem_wmask),
        .addr  (mem_addr),
        .din   (mem_din),
        .dout  (mem_dout)
    );

endmodule

`default_nettype wire

/* sim/tb_axil_spram.sv */
`default_nettype none

module tb_axil_spram
    import spram_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int DW         = 32;
    localparam int AW         = 8;
    localparam int off_w      = 2;          // byte offset bits of a 32 bit word
    localparam int n_words    = 2 ** AW;
    localparam int n_random   = 2000;
    localparam int n_ops      = 2 * n_words + 128 + 48 + 2 + n_random;
    localparam int rd_latency = 2;          // cycles from ar handshake to rvalid

    logic               clk;
    logic               rst_n;
    logic               awvalid;
    logic               awready;
    logic [axil_aw-1:0] awaddr;
    logic               wvalid;
    logic               wready;
    logic [DW-1:0]      wdata;
    logic [DW/8-1:0]    wstrb;
    logic               bvalid;
    logic               bready;
    logic [1:0]         bresp;
    logic               arvalid;
    logic               arready;
    logic [axil_aw-1:0] araddr;
    logic               rvalid;
    logic               rready;
    logic [DW-1:0]      rdata;
    logic [1:0]         rresp;

    logic [DW-1:0] model [n_words];   // reference copy of the memory

    axil_spram_top #(.DW(DW), .AW(AW)) DUT (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // each operation takes well under 40 cycles
    initial begin
        #(n_ops * 40 * 10);
        $display("Bus hung: the run went past its time limit");
        $display("Done: errors found");
        $fatal(1, "watchdog expired");
    end

    task automatic check(input logic [DW-1:0] actual, input logic [DW-1:0] expected,
                         input string what);
        if (actual !== expected) begin
            $display("Fail at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
            $display("Done: errors found");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic check_no_ready(input string what);
        check(awready, 1'b0, {"awready while ", what});
        check(wready, 1'b0, {"wready while ", what});
        check(arready, 1'b0, {"arready while ", what});
    endtask

    // other channels knock while a response waits
    task automatic offer_other(input logic wr_on, input logic rd_on);
        awvalid = wr_on;
        wvalid  = wr_on;
        arvalid = rd_on;
    endtask

    function automatic logic addr_ok(input logic [axil_aw-1:0] addr);
        return addr[axil_aw-1:AW+off_w] == '0;   // bits above the word index
    endfunction

    function automatic logic [axil_aw-1:0] word_addr(input int idx);
        return axil_aw'(idx) << off_w;
    endfunction

    function automatic logic [DW-1:0] fill_word(input logic [AW-1:0] idx);
        return {idx, ~idx, idx ^ 8'h5a, idx + 8'h3c};
    endfunction

    task automatic axil_write(input logic [axil_aw-1:0] addr, input logic [DW-1:0] data,
                              input logic [DW/8-1:0] strb, input logic [1:0] exp_resp);
        int delay;
        delay   = $urandom_range(5, 0);
        awvalid = 1'b1;
        awaddr  = addr;
        wvalid  = 1'b1;
        wdata   = data;
        wstrb   = strb;
        #1;
        while (!(awready && wready)) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        for (int k = 0; k < delay; k++) begin
            offer_other(k[0], 1'b1);   // ar alone on even cycles
            #1;
            check(bvalid, 1'b1, "bvalid held");
            check(bresp, exp_resp, "bresp held");
            check_no_ready("b pending");
            @(negedge clk);
        end
        offer_other(1'b0, 1'b0);
        bready = 1'b1;
        #1;
        check(bvalid, 1'b1, "bvalid at accept");
        check(bresp, exp_resp, "bresp at accept");
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic axil_read(input logic [axil_aw-1:0] addr, input logic [DW-1:0] exp_data,
                             input logic [1:0] exp_resp);
        int delay;
        int lat;
        delay   = $urandom_range(5, 0);
        arvalid = 1'b1;
        araddr  = addr;
        #1;
        while (!arready) begin
            @(negedge clk);
            #1;
        end
        lat = 0;
        do begin
            @(negedge clk);
            arvalid = 1'b0;
            lat++;
            #1;
        end while (!rvalid && lat < 8);
        check(lat, rd_latency, "read latency");
        for (int k = 0; k < delay; k++) begin
            offer_other(k[0], 1'b1);   // ar alone on even cycles
            #1;
            check(rvalid, 1'b1, "rvalid held");
            check(rdata, exp_data, "rdata held");
            check(rresp, exp_resp, "rresp held");
            check_no_ready("r pending");
            @(negedge clk);
        end
        offer_other(1'b0, 1'b0);
        rready = 1'b1;
        #1;
        check(rvalid, 1'b1, "rvalid at accept");
        check(rdata, exp_data, "rdata at accept");
        check(rresp, exp_resp, "rresp at accept");
        @(negedge clk);
        rready = 1'b0;
    endtask

    task automatic apply_write(input logic [axil_aw-1:0] addr, input logic [DW-1:0] data,
                               input logic [DW/8-1:0] strb);
        if (addr_ok(addr)) begin
            for (int i = 0; i < DW / 8; i++) begin
                if (strb[i]) begin
                    model[addr[off_w +: AW]][8*i +: 8] = data[8*i +: 8];
                end
            end
        end
    endtask

    task automatic write_word(input logic [axil_aw-1:0] addr, input logic [DW-1:0] data,
                              input logic [DW/8-1:0] strb);
        axil_write(addr, data, strb, addr_ok(addr) ? resp_okay : resp_slverr);
        apply_write(addr, data, strb);
    endtask

    task automatic read_compare(input logic [axil_aw-1:0] addr);
        if (addr_ok(addr)) begin
            axil_read(addr, model[addr[off_w +: AW]], resp_okay);
        end else begin
            axil_read(addr, '0, resp_slverr);   // out of range reads as zero
        end
    endtask

    initial begin
        logic [axil_aw-1:0] addr;
        logic [AW-1:0]      idx;
        logic [DW-1:0]      data;
        void'($urandom(32'h1f44));
        rst_n   = 1'b0;
        awaddr  = '0;
        wdata   = '0;
        wstrb   = '0;
        araddr  = '0;
        bready  = 1'b0;
        rready  = 1'b0;
        offer_other(1'b0, 1'b0);
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        #1;
        check_no_ready("idle after reset");
        check(bvalid, 1'b0, "bvalid after reset");
        check(rvalid, 1'b0, "rvalid after reset");
        @(negedge clk);

        // fill every word of every bank and read it all back
        for (int i = 0; i < n_words; i++) begin
            write_word(word_addr(i), fill_word(AW'(i)), 4'hf);
        end
        for (int i = 0; i < n_words; i++) begin
            read_compare(word_addr(i));
        end

        // partial strobes
        for (int i = 0; i < 64; i++) begin
            addr = word_addr($urandom_range(n_words - 1, 0));
            write_word(addr, $urandom, 4'($urandom_range(15, 0)));
            read_compare(addr);
        end

        // out of range writes leave the aliased in-range word untouched
        for (int i = 0; i < 16; i++) begin
            idx  = AW'($urandom);
            addr = {6'($urandom_range(63, 1)), idx, 2'b00};
            write_word(addr, $urandom, 4'hf);
            read_compare(addr);
            read_compare(word_addr(idx));
        end

        // aw, w and ar together on one address
        addr    = word_addr(8'h2a);
        data    = ~model[8'h2a];
        awvalid = 1'b1;
        awaddr  = addr;
        wvalid  = 1'b1;
        wdata   = data;
        wstrb   = 4'hf;
        arvalid = 1'b1;
        araddr  = addr;
        #1;
        check(awready, 1'b1, "awready with all offered");
        check(wready, 1'b1, "wready with all offered");
        check(arready, 1'b0, "arready with all offered");
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        #1;
        check(bvalid, 1'b1, "bvalid after collision");
        check(bresp, resp_okay, "bresp after collision");
        check(arready, 1'b0, "arready behind write");
        bready = 1'b1;
        @(negedge clk);
        bready = 1'b0;
        apply_write(addr, data, 4'hf);
        read_compare(addr);   // arvalid still up from above

        // random mix over the whole space
        for (int i = 0; i < n_random; i++) begin
            addr = word_addr($urandom_range(n_words - 1, 0));
            if ($urandom_range(1, 0)) begin
                write_word(addr, $urandom, 4'($urandom_range(15, 0)));
            end else begin
                read_compare(addr);
            end
        end

        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
verilog/spram_pkg.sv
verilog/sram_macro.sv
verilog/spram_tiled.sv
verilog/axil_spram_ctrl.sv
verilog/axil_spram_top.sv
sim/tb_axil_spram.sv

/* Bender.yml */
package:
  name: axil_spram

sources:
  - verilog/spram_pkg.sv
  - verilog/sram_macro.sv
  - verilog/spram_tiled.sv
  - verilog/axil_spram_ctrl.sv
  - verilog/axil_spram_top.sv
  - target: simulation
    files:
      - sim/tb_axil_spram.sv
